//--- verilog.f
+incdir+source
source/apuPkg.sv
source/apuRegBus.sv
source/envelopeUnit.sv
source/lengthCounter.sv
source/squareChannel.sv
source/apuControl.sv
source/apuTop.sv
sim/apu_properties.sv
sim/apuChecker.sv
sim/apuTb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module apuTb -f verilog.f -o simApu &&
  ./obj_dir/simApu | tee /dev/stderr | grep -q "Simulation PASSED" ||
  exit 1

exit 0

//--- sim/apuTb.sv
/* Sound generator testbench */

`timescale 1ns/1ns
`include "apu_consts.svh"

module apuTb;

  logic i_rewind_time_to_save = 1'b0;
  logic reset;
  logic i_ce;
  logic i_write;
  logic i_read;
  logic [4:0] i_addr;
  logic [7:0] i_writeData;
  logic [7:0] o_status;
  logic o_irq;
  apuPkg::volume_t o_pulse1Sample;
  apuPkg::volume_t o_pulse2Sample;

  integer seed = 32'hdb11_47fc;
  int frame4 = int'(`APU_STEP4) + 1;
  int frame5 = int'(`APU_STEP5) + 1;

  always #5 i_rewind_time_to_save = ~i_rewind_time_to_save;

  apuTop i_apuTop (.*);

  apuChecker i_checker (
    .i_rewind_time_to_save(i_rewind_time_to_save),
    .i_status(o_status),
    .i_irq(o_irq),
    .i_pulse1Sample(o_pulse1Sample),
    .i_pulse2Sample(o_pulse2Sample)
  );

  // Write lands on the second edge
  task automatic writeReg(input logic [4:0] addr, input logic [7:0] data);
    @(posedge i_rewind_time_to_save);
    i_write <= 1'b1;
    i_addr <= addr;
    i_writeData <= data;
    @(posedge i_rewind_time_to_save);
    i_write <= 1'b0;
  endtask

  task automatic readStatus();
    @(posedge i_rewind_time_to_save);
    i_read <= 1'b1;
    i_addr <= `APU_REG_ENABLE;
    @(posedge i_rewind_time_to_save);
    i_read <= 1'b0;
  endtask

  // Hang guard
  initial begin
    #10_000_000;
    $display("Timeout: the test sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int ch;
    logic [4:0] idx;
    logic [4:0] base;
    logic [10:0] period;
    apuPkg::volume_t vol;
    logic [1:0] duty;
    reset = 1'b1;
    i_ce = 1'b1;
    i_write = 1'b0;
    i_read = 1'b0;
    i_addr = '0;
    i_writeData = '0;
    repeat (8) @(posedge i_rewind_time_to_save);
    reset <= 1'b0;
    i_checker.checkIdle("reset");

    // ------------------------------------------------------------------------
    // Length load and disable
    // ------------------------------------------------------------------------
    ch = {$random(seed)} % 2;
    base = 5'(ch * 4);
    idx = 5'($random(seed));
    writeReg(`APU_REG_ENABLE, 8'(1 << ch));
    writeReg(base + 5'd3, {idx, 3'b000});
    i_checker.checkLoad("length_load", ch, idx);
    writeReg(`APU_REG_ENABLE, 8'h00);
    i_checker.waitBit("length_disable", ch, 1'b0, 1);

    // Index 3 loads a count of two half frames
    writeReg(`APU_REG_FRAME, 8'h00);
    writeReg(`APU_REG_ENABLE, 8'h03);
    writeReg(base, 8'h10);
    writeReg(base + 5'd3, 8'h18);
    i_checker.waitBit("length_expire", ch, 1'b0, 2 * frame4);
    writeReg(base, 8'h30);   // Halt set
    writeReg(base + 5'd3, 8'h18);
    i_checker.holdBit("length_halt", ch, 1'b1, 2 * frame4);

    // ------------------------------------------------------------------------
    // Frame interrupt
    // ------------------------------------------------------------------------
    readStatus();
    writeReg(`APU_REG_FRAME, 8'h00);
    i_checker.waitBit("irq_4step", 8, 1'b1, frame4 + 4);
    readStatus();
    i_checker.waitBit("irq_read_clear", 8, 1'b0, 1);
    writeReg(`APU_REG_FRAME, 8'h80);
    i_checker.holdBit("irq_5step", 8, 1'b0, 2 * frame5);
    writeReg(`APU_REG_FRAME, 8'h40);
    i_checker.holdBit("irq_inhibit", 8, 1'b0, 2 * frame4);

    // ------------------------------------------------------------------------
    // Sample gating with constant volume and halt
    // ------------------------------------------------------------------------
    ch = {$random(seed)} % 2;
    base = 5'(ch * 4);
    vol = 4'(1 + {$random(seed)} % 15);
    duty = 2'($random(seed));
    period = 11'(64 + {$random(seed)} % 960);
    writeReg(base, {duty, 2'b11, vol});
    writeReg(base + 5'd1, 8'h00);
    writeReg(base + 5'd2, period[7:0]);
    writeReg(base + 5'd3, {5'd1, period[10:8]});
    i_checker.sampleWindow("sample_levels", ch, vol, period, 40000);
    period = 11'({$random(seed)} % 64);
    writeReg(base + 5'd2, period[7:0]);
    writeReg(base + 5'd3, {5'd1, period[10:8]});
    i_checker.sampleWindow("sample_short_period", ch, vol, period, 4000);

    i_checker.reportSummary();
    if (i_checker.failCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim/apuChecker.sv
/* Sound generator reference checks */

`timescale 1ns/1ns
`include "apu_consts.svh"

module apuChecker (
  input logic            i_rewind_time_to_save,
  input logic [7:0]      i_status,
  input logic            i_irq,
  input apuPkg::volume_t i_pulse1Sample,
  input apuPkg::volume_t i_pulse2Sample
);

  int testCount = 0;
  int failCount = 0;
  int errorCount = 0;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic lengthNonzero(input logic [4:0] idx);
    logic [7:0] lengthValues [32];
    lengthValues = '{8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
                     8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
                     8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
                     8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30};
    return lengthValues[idx] != 8'd0;
  endfunction

  // Sweep off and not negated so the target is twice the period
  function automatic logic periodSounds(input logic [10:0] period);
    return (period[10:3] >= 8'd8) && (({1'b0, period} << 1) < 12'd2048);
  endfunction

  function automatic logic pick(input int sel);
    return (sel == 8) ? i_irq : i_status[sel];
  endfunction

  task automatic finishTest(input string name, input int errs);
    testCount++;
    errorCount += errs;
    if (errs == 0) begin
      $display("Test %s: passed", name);
    end else begin
      failCount++;
      $display("Test %s: failed with %0d errors", name, errs);
    end
  endtask

  task automatic checkIdle(input string name);
    int errs;
    errs = 0;
    @(negedge i_rewind_time_to_save);
    if (i_status !== 8'h00 || i_irq !== 1'b0) begin
      $display("Error %s: expected status 0x00 irq 0, actual status 0x%02h irq %b",
               name, i_status, i_irq);
      errs++;
    end
    if (i_pulse1Sample !== 4'd0 || i_pulse2Sample !== 4'd0) begin
      $display("Error %s: expected samples 0 0, actual %0d %0d", name,
               i_pulse1Sample, i_pulse2Sample);
      errs++;
    end
    finishTest(name, errs);
  endtask

  // Sel picks a status bit or 8 for the IRQ pin
  task automatic waitBit(input string name, input int sel, input logic exp, input int limit);
    int n;
    n = 0;
    @(negedge i_rewind_time_to_save);
    while (pick(sel) !== exp && n < limit) begin
      @(negedge i_rewind_time_to_save);
      n++;
    end
    if (pick(sel) !== exp) begin
      $display("Error %s: expected %b, actual %b after %0d cycles", name, exp,
               pick(sel), limit);
      finishTest(name, 1);
    end else begin
      finishTest(name, 0);
    end
  endtask

  task automatic holdBit(input string name, input int sel, input logic exp, input int cycles);
    int errs;
    errs = 0;
    for (int n = 0; n < cycles && errs == 0; n++) begin
      @(negedge i_rewind_time_to_save);
      if (pick(sel) !== exp) begin
        $display("Error %s: expected %b, actual %b at cycle %0d", name, exp, pick(sel), n);
        errs++;
      end
    end
    finishTest(name, errs);
  endtask

  // Load shows in the status right after the write edge
  task automatic checkLoad(input string name, input int ch, input logic [4:0] idx);
    waitBit(name, ch, lengthNonzero(idx), 0);
  endtask

  task automatic sampleWindow(input string name, input int ch, input apuPkg::volume_t vol,
                              input logic [10:0] period, input int cycles);
    int errs;
    logic sounds;
    logic seenLow;
    logic seenHigh;
    apuPkg::volume_t s;
    errs = 0;
    sounds = periodSounds(period);
    seenLow = 1'b0;
    seenHigh = 1'b0;
    for (int n = 0; n < cycles; n++) begin
      @(negedge i_rewind_time_to_save);
      s = (ch == 0) ? i_pulse1Sample : i_pulse2Sample;
      if (s == 4'd0)
        seenLow = 1'b1;
      else if (sounds && s == vol)
        seenHigh = 1'b1;
      else if (errs == 0) begin
        $display("Error %s: expected %0d, actual %0d", name, sounds ? vol : 4'd0, s);
        errs++;
      end
    end
    if (sounds && !(seenLow && seenHigh)) begin
      $display("%s: the sample did not show both levels within the window", name);
      errs++;
    end
    finishTest(name, errs);
  endtask

  task automatic reportSummary();
    $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
  endtask

endmodule

//--- sim/apu_properties.sv
/* Top level status properties */

`timescale 1ns/1ns
`include "apu_consts.svh"

module apuProperties (
  input logic       i_rewind_time_to_save,
  input logic       reset,
  input logic       i_ce,
  input logic       i_read,
  input logic [4:0] i_addr,
  input logic [7:0] i_status,
  input logic       i_irq,
  input logic       i_flagSet
);

  irqMatchesStatus: assert property (@(posedge i_rewind_time_to_save) disable iff (reset)
    i_irq == i_status[6]) else $error("IRQ output differs from status bit 6");

  unusedBitsZero: assert property (@(posedge i_rewind_time_to_save) disable iff (reset)
    (i_status[7] == 1'b0) && (i_status[5:2] == 4'b0000))
    else $error("Unused status bits are set");

  // No interrupt right after reset
  irqLowAfterReset: assert property (@(posedge i_rewind_time_to_save)
    reset |=> !i_irq) else $error("IRQ high after reset");

  readClearsFlag: assert property (@(posedge i_rewind_time_to_save) disable iff (reset)
    (i_ce && i_read && i_addr == `APU_REG_ENABLE && i_status[6] && !i_flagSet)
    |=> !i_status[6]) else $error("Status read did not clear the frame interrupt");

endmodule

bind apuTop apuProperties i_properties (
  .i_rewind_time_to_save(i_rewind_time_to_save),
  .reset(reset),
  .i_ce(i_ce),
  .i_read(i_read),
  .i_addr(i_addr),
  .i_status(o_status),
  .i_irq(o_irq),
  .i_flagSet(i_apuControl.flagSet)
);

//--- source/apuTop.sv
/* Two-channel pulse sound generator */

`timescale 1ns/1ns
`include "apu_consts.svh"

module apuTop (
  input  logic                       i_rewind_time_to_save,
  input  logic                       reset,
  input  logic                       i_ce,
  input  logic                       i_write,
  input  logic                       i_read,
  input  logic [`APU_ADDR_WIDTH-1:0] i_addr,
  input  logic [`APU_DATA_WIDTH-1:0] i_writeData,
  output logic [`APU_DATA_WIDTH-1:0] o_status,
  output logic                       o_irq,
  output apuPkg::volume_t            o_pulse1Sample,
  output apuPkg::volume_t            o_pulse2Sample
);

  apuPkg::frameClocks_t frameClocks;
  logic [1:0] channelEnable;
  logic [1:0] lengthActive;    // Bit 0 is pulse 1

  apuRegBus regBus ();

  apuControl i_apuControl (
    .i_rewind_time_to_save(i_rewind_time_to_save),
    .reset(reset),
    .i_ce(i_ce),
    .i_write(i_write),
    .i_read(i_read),
    .i_addr(i_addr),
    .i_writeData(i_writeData),
    .regBus(regBus.control),
    .o_frameClocks(frameClocks),
    .o_channelEnable(channelEnable),
    .i_lengthActive(lengthActive),
    .o_status(o_status),
    .o_irq(o_irq)
  );

  squareChannel #(.CHANNEL_INDEX(0)) i_pulse1 (
    .i_rewind_time_to_save(i_rewind_time_to_save),
    .reset(reset),
    .regBus(regBus.channel),
    .i_frameClocks(frameClocks),
    .i_enable(channelEnable[0]),
    .o_lengthActive(lengthActive[0]),
    .o_sample(o_pulse1Sample)
  );

  squareChannel #(.CHANNEL_INDEX(1)) i_pulse2 (
    .i_rewind_time_to_save(i_rewind_time_to_save),
    .reset(reset),
    .regBus(regBus.channel),
    .i_frameClocks(frameClocks),
    .i_enable(channelEnable[1]),
    .o_lengthActive(lengthActive[1]),
    .o_sample(o_pulse2Sample)
  );

endmodule

//--- source/apuControl.sv
/* Register decode and frame sequencer */

`timescale 1ns/1ns
`include "apu_consts.svh"

module apuControl (
  input  logic                       i_rewind_time_to_save,
  input  logic                       reset,
  input  logic                       i_ce,
  input  logic                       i_write,
  input  logic                       i_read,
  input  logic [`APU_ADDR_WIDTH-1:0] i_addr,
  input  logic [`APU_DATA_WIDTH-1:0] i_writeData,
  apuRegBus.control                  regBus,
  output apuPkg::frameClocks_t       o_frameClocks,
  output logic [1:0]                 o_channelEnable,
  input  logic [1:0]                 i_lengthActive,
  output logic [`APU_DATA_WIDTH-1:0] o_status,
  output logic                       o_irq
);

  logic enableWrite;
  logic frameWrite;
  logic statusRead;
  logic frameMode;      // 1 selects 5-step
  logic irqInhibit;
  logic frameFlag;
  logic frameIrq;
  logic flagSet;
  logic flagClear;
  logic frameWrap;
  logic [`APU_FRAME_WIDTH-1:0] frameCount;
  apuPkg::frameClocks_t stepClocks;

  // ---------------------------------------------------------------------------
  // Address decode onto the channel bus
  // ---------------------------------------------------------------------------
  assign regBus.ce = i_ce;
  assign regBus.pulse1Write = i_write && (i_addr[4:2] == 3'd0);
  assign regBus.pulse2Write = i_write && (i_addr[4:2] == 3'd1);
  assign regBus.regIndex = i_addr[1:0];
  assign regBus.data = i_writeData;

  assign enableWrite = i_write && (i_addr == `APU_REG_ENABLE);
  assign frameWrite = i_write && (i_addr == `APU_REG_FRAME);
  assign statusRead = i_read && (i_addr == `APU_REG_ENABLE);

  // Step matches on the current count
  always_comb begin
    stepClocks = '0;
    frameWrap = 1'b0;
    case (frameCount)
      `APU_STEP1, `APU_STEP3: stepClocks.quarter = 1'b1;
      `APU_STEP2: begin
        stepClocks.quarter = 1'b1;
        stepClocks.half = 1'b1;
      end
      `APU_STEP4: begin
        if (!frameMode) begin
          stepClocks = '{quarter: 1'b1, half: 1'b1};
          frameWrap = 1'b1;
        end
      end
      `APU_STEP5: begin
        if (frameMode) begin
          stepClocks = '{quarter: 1'b1, half: 1'b1};
          frameWrap = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign flagSet = frameWrap && !frameMode;  // Only the 4-step wrap raises it
  assign flagClear = statusRead || (frameWrite && i_writeData[6]);

  // ---------------------------------------------------------------------------
  // Frame counter, interrupt flag and control registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_rewind_time_to_save) begin
    if (reset) begin
      frameCount <= '0;
      o_frameClocks <= '0;
      frameMode <= 1'b0;
      irqInhibit <= 1'b0;
      frameFlag <= 1'b0;
      o_channelEnable <= '0;
    end else if (i_ce) begin
      o_frameClocks <= stepClocks;
      frameCount <= frameWrap ? '0 : frameCount + 1'b1;

      if (flagSet)
        frameFlag <= 1'b1;
      else if (flagClear)
        frameFlag <= 1'b0;

      if (enableWrite)
        o_channelEnable <= i_writeData[1:0];

      if (frameWrite) begin
        frameMode <= i_writeData[7];
        irqInhibit <= i_writeData[6];
        frameCount <= '0;
        if (i_writeData[7])
          o_frameClocks <= '{quarter: 1'b1, half: 1'b1};  // 5-step clocks at once
      end
    end
  end

  assign frameIrq = frameFlag && !irqInhibit;
  assign o_irq = frameIrq;
  assign o_status = {1'b0, frameIrq, 4'b0000, i_lengthActive};

endmodule

//--- source/squareChannel.sv
/* Pulse channel */

`timescale 1ns/1ns
`include "apu_consts.svh"

module squareChannel #(
  parameter int CHANNEL_INDEX = 0   // 0 is pulse 1, 1 is pulse 2
) (
  input  logic                 i_rewind_time_to_save,
  input  logic                 reset,
  apuRegBus.channel            regBus,
  input  apuPkg::frameClocks_t i_frameClocks,
  input  logic                 i_enable,
  output logic                 o_lengthActive,
  output apuPkg::volume_t      o_sample
);

  logic chanWrite;
  logic lengthLoad;

  // Register 0
  apuPkg::dutyMode_t duty;
  logic envLoop;        // Also halts the length counter
  logic constVolume;
  apuPkg::volume_t volume;

  // Register 1
  logic sweepEnable;
  logic [2:0] sweepPeriod;
  logic sweepNegate;
  logic [2:0] sweepShift;
  logic sweepReload;
  logic [2:0] sweepDivider;

  apuPkg::timerPeriod_t period;
  logic [11:0] timer;
  logic [2:0] seqPos;

  logic [10:0] shiftedPeriod;
  logic [10:0] sweepDelta;
  logic [11:0] sweepTarget;
  logic periodValid;
  logic dutyOn;
  apuPkg::volume_t envLevel;

  assign chanWrite = (CHANNEL_INDEX == 0) ? regBus.pulse1Write : regBus.pulse2Write;
  assign lengthLoad = chanWrite && (regBus.regIndex == 2'd3);

  // ---------------------------------------------------------------------------
  // Sweep target and period check
  // ---------------------------------------------------------------------------
  assign shiftedPeriod = period >> sweepShift;
  // Pulse 1 negates in ones' complement, pulse 2 in two's complement
  assign sweepDelta = sweepNegate ? (~shiftedPeriod + 11'(CHANNEL_INDEX)) : shiftedPeriod;
  assign sweepTarget = {1'b0, period} + {1'b0, sweepDelta};
  assign periodValid = (period[10:3] >= `APU_MIN_PERIOD) && (sweepNegate || !sweepTarget[11]);

  always_ff @(posedge i_rewind_time_to_save) begin
    if (reset) begin
      duty <= apuPkg::DUTY_12;
      envLoop <= 1'b0;
      constVolume <= 1'b0;
      volume <= '0;
      sweepEnable <= 1'b0;
      sweepPeriod <= '0;
      sweepNegate <= 1'b0;
      sweepShift <= '0;
      sweepReload <= 1'b0;
      sweepDivider <= '0;
      period <= '0;
      timer <= '0;
      seqPos <= '0;
    end else if (regBus.ce) begin
      // Timer runs at half rate through the doubled reload
      if (timer == '0) begin
        timer <= {period, 1'b0};
        seqPos <= seqPos - 1'b1;
      end else begin
        timer <= timer - 1'b1;
      end

      if (i_frameClocks.half) begin
        if (sweepDivider == '0) begin
          sweepDivider <= sweepPeriod;
          if (sweepEnable && sweepShift != '0 && periodValid)
            period <= sweepTarget[10:0];
        end else begin
          sweepDivider <= sweepDivider - 1'b1;
        end
        if (sweepReload)
          sweepDivider <= sweepPeriod;
        sweepReload <= 1'b0;
      end

      // Register writes take priority over the clocking above
      if (chanWrite) begin
        case (regBus.regIndex)
          2'd0: begin
            duty <= apuPkg::dutyMode_t'(regBus.data[7:6]);
            envLoop <= regBus.data[5];
            constVolume <= regBus.data[4];
            volume <= regBus.data[3:0];
          end
          2'd1: begin
            sweepEnable <= regBus.data[7];
            sweepPeriod <= regBus.data[6:4];
            sweepNegate <= regBus.data[3];
            sweepShift <= regBus.data[2:0];
            sweepReload <= 1'b1;
          end
          2'd2: period[7:0] <= regBus.data;
          default: begin
            period[10:8] <= regBus.data[2:0];
            seqPos <= '0;               // Restart the duty cycle
          end
        endcase
      end
    end
  end

  // Duty step decode
  always_comb begin
    case (duty)
      apuPkg::DUTY_12: dutyOn = (seqPos == 3'd7);
      apuPkg::DUTY_25: dutyOn = (seqPos >= 3'd6);
      apuPkg::DUTY_50: dutyOn = (seqPos >= 3'd4);
      default:         dutyOn = (seqPos < 3'd6);
    endcase
  end

  assign o_sample = (!o_lengthActive || !periodValid || !dutyOn) ? '0 :
                    (constVolume ? volume : envLevel);

  envelopeUnit i_envelope (
    .i_rewind_time_to_save(i_rewind_time_to_save),
    .reset(reset),
    .i_ce(regBus.ce),
    .i_quarterFrame(i_frameClocks.quarter),
    .i_restart(lengthLoad),
    .i_loop(envLoop),
    .i_divider(volume),
    .o_level(envLevel)
  );

  lengthCounter i_length (
    .i_rewind_time_to_save(i_rewind_time_to_save),
    .reset(reset),
    .i_ce(regBus.ce),
    .i_load(lengthLoad),
    .i_loadIndex(regBus.data[7:3]),
    .i_halfFrame(i_frameClocks.half),
    .i_halt(envLoop),
    .i_enable(i_enable),
    .o_active(o_lengthActive)
  );

endmodule

//--- source/lengthCounter.sv
/* Length counter with value table */

`timescale 1ns/1ns

module lengthCounter (
  input  logic       i_rewind_time_to_save,
  input  logic       reset,
  input  logic       i_ce,
  input  logic       i_load,
  input  logic [4:0] i_loadIndex,
  input  logic       i_halfFrame,
  input  logic       i_halt,
  input  logic       i_enable,
  output logic       o_active
);

  // ---------------------------------------------------------------------------
  // Length values indexed by register 3 bits 7..3
  // ---------------------------------------------------------------------------
  localparam apuPkg::lengthCount_t lengthTable [32] = '{
    8'h0A, 8'hFE, 8'h14, 8'h02, 8'h28, 8'h04, 8'h50, 8'h06,
    8'hA0, 8'h08, 8'h3C, 8'h0A, 8'h0E, 8'h0C, 8'h1A, 8'h0E,
    8'h0C, 8'h10, 8'h18, 8'h12, 8'h30, 8'h14, 8'h60, 8'h16,
    8'hC0, 8'h18, 8'h48, 8'h1A, 8'h10, 8'h1C, 8'h20, 8'h1E
  };

  apuPkg::lengthCount_t count;

  assign o_active = (count != '0);

  always_ff @(posedge i_rewind_time_to_save) begin
    if (reset) begin
      count <= '0;
    end else if (i_ce) begin
      if (!i_enable) begin
        count <= '0;                      // Held clear while disabled
      end else if (i_load) begin
        count <= lengthTable[i_loadIndex];
      end else if (i_halfFrame && !i_halt && count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- source/envelopeUnit.sv
/* Envelope generator */

`timescale 1ns/1ns
`include "apu_consts.svh"

module envelopeUnit (
  input  logic            i_rewind_time_to_save,
  input  logic            reset,
  input  logic            i_ce,
  input  logic            i_quarterFrame,
  input  logic            i_restart,       // Register 3 write
  input  logic            i_loop,
  input  apuPkg::volume_t i_divider,
  output apuPkg::volume_t o_level
);

  logic startFlag;
  apuPkg::volume_t dividerCount;
  apuPkg::volume_t decayLevel;

  assign o_level = decayLevel;

  always_ff @(posedge i_rewind_time_to_save) begin
    if (reset) begin
      startFlag <= 1'b0;
      dividerCount <= '0;
      decayLevel <= '0;
    end else if (i_ce) begin
      if (i_quarterFrame) begin
        if (startFlag) begin
          // Deferred restart from the last register 3 write
          startFlag <= 1'b0;
          dividerCount <= i_divider;
          decayLevel <= `APU_ENV_MAX;
        end else if (dividerCount == '0) begin
          dividerCount <= i_divider;
          if (decayLevel != '0)
            decayLevel <= decayLevel - 1'b1;
          else if (i_loop)
            decayLevel <= `APU_ENV_MAX;  // Sawtooth when looping
        end else begin
          dividerCount <= dividerCount - 1'b1;
        end
      end

      // New restart request outranks the clear above
      if (i_restart)
        startFlag <= 1'b1;
    end
  end

endmodule

//--- source/apuRegBus.sv
/* Channel register write bus */

`timescale 1ns/1ns
`include "apu_consts.svh"

interface apuRegBus;

  logic ce;
  logic pulse1Write;   // Address 0..3
  logic pulse2Write;   // Address 4..7
  apuPkg::regIndex_t regIndex;
  logic [`APU_DATA_WIDTH-1:0] data;

  modport control (
    output ce,
    output pulse1Write,
    output pulse2Write,
    output regIndex,
    output data
  );

  modport channel (
    input ce,
    input pulse1Write,
    input pulse2Write,
    input regIndex,
    input data
  );

endinterface

//--- source/apuPkg.sv
/* Sound generator types */

package apuPkg;

  // Sample or volume level
  typedef logic [3:0] volume_t;

  // Channel timer period of 11 bits as written by the CPU
  typedef logic [10:0] timerPeriod_t;

  typedef logic [7:0] lengthCount_t;

  // Register offset within one pulse channel
  typedef logic [1:0] regIndex_t;

  // One-cycle frame sequencer pulses
  typedef struct packed {
    logic quarter;   // Envelope clock
    logic half;      // Length and sweep clock
  } frameClocks_t;

  // Duty field of register 0
  typedef enum logic [1:0] {
    DUTY_12 = 2'd0,
    DUTY_25 = 2'd1,
    DUTY_50 = 2'd2,
    DUTY_75N = 2'd3  // 25% inverted
  } dutyMode_t;

endpackage

//--- source/apu_consts.svh
/* Sound generator constants */

`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// ---------------------------------------------------------------------------
// Frame sequencer step points in enabled cycles
// ---------------------------------------------------------------------------
`define APU_FRAME_WIDTH 16
`define APU_STEP1 16'd7457
`define APU_STEP2 16'd14913
`define APU_STEP3 16'd22371
`define APU_STEP4 16'd29829   // Last step of 4-step mode
`define APU_STEP5 16'd37281   // Last step of 5-step mode

// ---------------------------------------------------------------------------
// Register map and bus widths
// ---------------------------------------------------------------------------
`define APU_ADDR_WIDTH 5
`define APU_DATA_WIDTH 8
`define APU_REG_ENABLE 5'h15  // Channel enable and status read
`define APU_REG_FRAME 5'h17   // Frame mode and IRQ inhibit

// Channel limits
`define APU_ENV_MAX 4'd15
`define APU_MIN_PERIOD 8'd8   // Compared against period bits 10..3

`endif
